// File: inst_pkg.sv
package inst_pkg;

    // queue geometry
    localparam int FIFO_DEPTH = 16;
    localparam int PTR_W = 4;
    // count must reach FIFO_DEPTH, so one bit wider than a pointer
    localparam int CNT_W = PTR_W + 1;

    // fetch start address after reset
    localparam logic [31:0] RESET_PC = 32'h0000_0000;

    // opcode / funct encodings seen by issue
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_BEQ = 6'b000100;
    localparam logic [5:0] OP_BNE = 6'b000101;
    localparam logic [5:0] FN_JR = 6'b001000;

    // r-type layout
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    // i-type layout
    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fields_t;

    // one instruction word, two views
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } mips_word_u;

    // fetch -> queue, up to two words per cycle
    typedef struct packed {
        logic        wr1;
        logic        wr2;
        logic [31:0] pc1;
        logic [31:0] pc2;
        logic [31:0] word1;
        logic [31:0] word2;
    } fetch_pair_t;

    // one issue slot towards decode
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] word;
        logic        in_delay_slot;
    } issue_slot_t;

endpackage

// File: fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
    import inst_pkg::*;
(
    input  logic        clk,
    input  logic        fifo_rst,
    input  logic        flush,
    input  logic [31:0] flush_pc,
    input  logic        no_room,
    output logic        imem_req,
    output logic [31:0] imem_addr,
    input  logic        imem_valid,
    input  logic [63:0] imem_data,
    output fetch_pair_t push
);

    // next fetch address, low bits only meaningful right after a restart
    logic [31:0] pc;
    // first pair after restart starts at the upper word
    logic        start_upper;
    // one idle cycle after reset or flush
    logic        hold;
    // request in flight that still counts
    logic        pending;
    // aligned address and start half of the request in flight
    logic [31:0] pend_addr;
    logic        pend_upper;
    logic        resp;

    // memory works on aligned pairs
    assign imem_addr = {pc[31:3], 3'b000};
    // queue keeps four free slots, so in-flight pairs always fit
    assign imem_req = !hold && !no_room;

    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            pc <= RESET_PC;
            start_upper <= RESET_PC[2];
            hold <= 1'b1;
            pending <= 1'b0;
        end else if (flush) begin
            // restart at target, drop whatever is still coming back
            pc <= flush_pc;
            start_upper <= flush_pc[2];
            hold <= 1'b1;
            pending <= 1'b0;
        end else begin
            hold <= 1'b0;
            pending <= imem_req;
            if (imem_req) begin
                pc <= imem_addr + 32'd8;
                start_upper <= 1'b0;
            end
        end
    end

    // tag of the request, used when its data returns
    always_ff @(posedge clk) begin
        if (imem_req) begin
            pend_addr <= imem_addr;
            pend_upper <= start_upper;
        end
    end

    assign resp = pending && imem_valid;

    always_comb begin
        push.wr1 = resp;
        // upper-word start writes a single entry
        push.wr2 = resp && !pend_upper;
        push.pc1 = pend_upper ? pend_addr + 32'd4 : pend_addr;
        push.pc2 = pend_addr + 32'd4;
        // low word first on the bus
        push.word1 = pend_upper ? imem_data[63:32] : imem_data[31:0];
        push.word2 = imem_data[63:32];
    end

    // memory answers only what was asked one cycle earlier
    a_valid_after_req: assert property (
        @(posedge clk) disable iff (fifo_rst)
        imem_valid |-> $past(imem_req)
    );

endmodule

// File: inst_fifo.sv
`timescale 1ns/1ps

module inst_fifo
    import inst_pkg::*;
(
    input  logic        clk,
    input  logic        fifo_rst,
    input  logic        flush,
    input  fetch_pair_t push,
    input  logic        take1,
    input  logic        take2,
    output logic [31:0] head1_word,
    output logic [31:0] head2_word,
    output logic [31:0] head1_pc,
    output logic [31:0] head2_pc,
    output logic        head1_valid,
    output logic        head2_valid,
    output logic        no_room
);

    // payload storage
    logic [31:0] words[FIFO_DEPTH];
    logic [31:0] pcs[FIFO_DEPTH];

    // circular pointers, wrap at depth
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic [PTR_W-1:0] wr_ptr_nx;
    logic [PTR_W-1:0] rd_ptr_nx;

    assign wr_ptr_nx = wr_ptr + PTR_W'(1);
    assign rd_ptr_nx = rd_ptr + PTR_W'(1);

    // status
    assign head1_valid = (count != '0);
    assign head2_valid = (count > CNT_W'(1));
    // fewer than four free entries
    assign no_room = (count > CNT_W'(FIFO_DEPTH - 4));

    // head outputs, zero when the entry is not there
    always_comb begin
        head1_word = '0;
        head1_pc = '0;
        head2_word = '0;
        head2_pc = '0;
        if (head1_valid) begin
            head1_word = words[rd_ptr];
            head1_pc = pcs[rd_ptr];
        end
        if (head2_valid) begin
            head2_word = words[rd_ptr_nx];
            head2_pc = pcs[rd_ptr_nx];
        end
    end

    // storage writes, two ports
    always_ff @(posedge clk) begin
        if (push.wr1) begin
            words[wr_ptr] <= push.word1;
            pcs[wr_ptr] <= push.pc1;
        end
        if (push.wr2) begin
            words[wr_ptr_nx] <= push.word2;
            pcs[wr_ptr_nx] <= push.pc2;
        end
    end

    // write pointer
    always_ff @(posedge clk) begin
        if (fifo_rst || flush) begin
            wr_ptr <= '0;
        end else if (push.wr1 && push.wr2) begin
            wr_ptr <= wr_ptr + PTR_W'(2);
        end else if (push.wr1) begin
            wr_ptr <= wr_ptr_nx;
        end
    end

    // read pointer
    always_ff @(posedge clk) begin
        if (fifo_rst || flush) begin
            rd_ptr <= '0;
        end else if (take1 && take2) begin
            rd_ptr <= rd_ptr + PTR_W'(2);
        end else if (take1) begin
            rd_ptr <= rd_ptr_nx;
        end
    end

    // entry count, net of writes and pops
    always_ff @(posedge clk) begin
        if (fifo_rst || flush) begin
            count <= '0;
        end else begin
            case ({push.wr1, push.wr2, take1, take2})
                // two in, none out
                4'b1100: count <= count + CNT_W'(2);
                // net one in
                4'b1110, 4'b1000: count <= count + CNT_W'(1);
                // net one out
                4'b1011, 4'b0010: count <= count - CNT_W'(1);
                // two out
                4'b0011: count <= count - CNT_W'(2);
                // balanced or idle
                default: count <= count;
            endcase
        end
    end

    // fetch must respect no_room
    a_no_overflow: assert property (
        @(posedge clk) disable iff (fifo_rst || flush)
        push.wr1 |-> (count + CNT_W'(push.wr1) + CNT_W'(push.wr2)
                      <= CNT_W'(FIFO_DEPTH))
    );

    // issue only takes what is there
    a_no_underflow: assert property (
        @(posedge clk) disable iff (fifo_rst || flush)
        (take1 |-> count >= CNT_W'(1)) and (take2 |-> count >= CNT_W'(2))
    );

endmodule

// File: issue_unit.sv
`timescale 1ns/1ps

module issue_unit
    import inst_pkg::*;
(
    input  logic        clk,
    input  logic        fifo_rst,
    input  logic        flush,
    input  logic        issue_ready,
    input  logic [31:0] head1_word,
    input  logic [31:0] head2_word,
    input  logic [31:0] head1_pc,
    input  logic [31:0] head2_pc,
    input  logic        head1_valid,
    input  logic        head2_valid,
    output logic        take1,
    output logic        take2,
    output issue_slot_t master,
    output issue_slot_t slave
);

    mips_word_u m_inst;
    mips_word_u s_inst;

    logic       m_is_rtype;
    logic       m_is_branch;
    logic [4:0] m_dest;
    logic       m_has_dest;
    logic       s_hazard;
    // next master sits in a delay slot
    logic       in_ds;

    assign m_inst = head1_word;
    assign s_inst = head2_word;

    // master decode
    assign m_is_rtype = (m_inst.r.opcode == OP_SPECIAL);
    assign m_is_branch = (m_inst.i.opcode == OP_BEQ) || (m_inst.i.opcode == OP_BNE)
                         || (m_is_rtype && m_inst.r.funct == FN_JR);
    // rd for r-type, rt for i-type
    assign m_dest = m_is_rtype ? m_inst.r.rd : m_inst.i.rt;
    // $zero is never a real destination
    assign m_has_dest = (m_dest != 5'd0);

    // slave reads what master writes
    assign s_hazard = m_has_dest && ((s_inst.i.rs == m_dest) || (s_inst.i.rt == m_dest));

    // issue decision
    assign take1 = head1_valid && issue_ready;
    // no slave behind a branch, so the delay slot is always a master
    assign take2 = take1 && head2_valid && !m_is_branch && !s_hazard;

    // delay-slot tracking, holds while decode stalls
    always_ff @(posedge clk) begin
        if (fifo_rst || flush) begin
            in_ds <= 1'b0;
        end else if (take1) begin
            in_ds <= m_is_branch && !take2;
        end
    end

    always_comb begin
        master.valid = take1;
        master.pc = head1_pc;
        master.word = head1_word;
        master.in_delay_slot = in_ds;
        slave.valid = take2;
        slave.pc = head2_pc;
        slave.word = head2_word;
        // slave never follows a branch
        slave.in_delay_slot = 1'b0;
    end

endmodule

// File: frontend_top.sv
`timescale 1ns/1ps

module frontend_top
    import inst_pkg::*;
(
    input  logic        clk,
    input  logic        fifo_rst,
    input  logic        flush,
    input  logic [31:0] flush_pc,
    input  logic        issue_ready,
    output logic        imem_req,
    output logic [31:0] imem_addr,
    input  logic        imem_valid,
    input  logic [63:0] imem_data,
    output issue_slot_t master,
    output issue_slot_t slave
);

    fetch_pair_t push;
    logic        no_room;
    logic [31:0] head1_word;
    logic [31:0] head2_word;
    logic [31:0] head1_pc;
    logic [31:0] head2_pc;
    logic        head1_valid;
    logic        head2_valid;
    logic        take1;
    logic        take2;

    // fetch side
    fetch_unit fetch_unit_inst (
        .clk        (clk),
        .fifo_rst   (fifo_rst),
        .flush      (flush),
        .flush_pc   (flush_pc),
        .no_room    (no_room),
        .imem_req   (imem_req),
        .imem_addr  (imem_addr),
        .imem_valid (imem_valid),
        .imem_data  (imem_data),
        .push       (push)
    );

    // instruction queue
    inst_fifo inst_fifo_inst (
        .clk         (clk),
        .fifo_rst    (fifo_rst),
        .flush       (flush),
        .push        (push),
        .take1       (take1),
        .take2       (take2),
        .head1_word  (head1_word),
        .head2_word  (head2_word),
        .head1_pc    (head1_pc),
        .head2_pc    (head2_pc),
        .head1_valid (head1_valid),
        .head2_valid (head2_valid),
        .no_room     (no_room)
    );

    // issue side
    issue_unit issue_unit_inst (
        .clk         (clk),
        .fifo_rst    (fifo_rst),
        .flush       (flush),
        .issue_ready (issue_ready),
        .head1_word  (head1_word),
        .head2_word  (head2_word),
        .head1_pc    (head1_pc),
        .head2_pc    (head2_pc),
        .head1_valid (head1_valid),
        .head2_valid (head2_valid),
        .take1       (take1),
        .take2       (take2),
        .master      (master),
        .slave       (slave)
    );

    // a flush leaves one quiet cycle on both ends of the front end
    a_flush_quiet: assert property (
        @(posedge clk) disable iff (fifo_rst)
        flush |=> !imem_req && !master.valid && !slave.valid
    );

endmodule

// File: tb_frontend.sv
`timescale 1ns/1ps

module tb_frontend
    import inst_pkg::*;
();

    // image layout, program words first, command triples after
    localparam int IMG_WORDS = 256;
    localparam int CMD_BASE = 256;
    localparam int IMG_SIZE = 320;
    localparam int CMD_FLUSH = 1;
    localparam int MAX_CYCLES = 3000;
    // instructions to see after the last restart
    localparam int RUN_AFTER_LAST = 200;

    logic        clk;
    logic        fifo_rst;
    logic        flush;
    logic [31:0] flush_pc;
    logic        issue_ready;
    logic        imem_req;
    logic [31:0] imem_addr;
    logic        imem_valid;
    logic [63:0] imem_data;
    issue_slot_t master;
    issue_slot_t slave;

    logic [31:0] img[IMG_SIZE];
    integer      seed;

    // reference state
    logic [31:0] cyc;
    logic [31:0] exp_pc;
    logic        exp_ds;
    logic        exp_req;
    // aligned pair address of the next request
    logic [31:0] exp_addr;
    int          avail;
    int          since_flush;
    int          cmd_idx;
    logic        quiet;
    logic        first_upper;
    logic        flush_now;
    logic [31:0] stall_end;
    // request seen last cycle, answered this cycle
    logic        req_q;
    logic        live_q;
    logic [31:0] addr_q;
    logic [31:0] m_word;
    logic [31:0] s_word;
    logic        m_exp;
    logic        s_exp;

    frontend_top frontend_top_inst (
        .clk         (clk),
        .fifo_rst    (fifo_rst),
        .flush       (flush),
        .flush_pc    (flush_pc),
        .issue_ready (issue_ready),
        .imem_req    (imem_req),
        .imem_addr   (imem_addr),
        .imem_valid  (imem_valid),
        .imem_data   (imem_data),
        .master      (master),
        .slave       (slave)
    );

    always #5 clk = ~clk;

    // 1 KB memory, wraps
    function automatic logic [31:0] word_at(input logic [31:0] pc);
        return img[pc[9:2]];
    endfunction

    // beq 04, bne 05, jr is special opcode with funct 08
    function automatic logic branch_word(input logic [31:0] w);
        return (w[31:26] == 6'h04) || (w[31:26] == 6'h05)
               || ((w[31:26] == 6'h00) && (w[5:0] == 6'h08));
    endfunction

    function automatic logic [4:0] dest_of(input logic [31:0] w);
        return (w[31:26] == 6'h00) ? w[15:11] : w[20:16];
    endfunction

    function automatic logic pair_ok(input logic [31:0] m, input logic [31:0] s);
        logic [4:0] d;
        d = dest_of(m);
        if (branch_word(m)) begin
            return 1'b0;
        end
        return (d == 5'd0) || ((s[25:21] != d) && (s[20:16] != d));
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Test failures found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    initial begin
        clk = 1'b0;
        fifo_rst = 1'b1;
        flush = 1'b0;
        flush_pc = '0;
        // decode ready during reset, so the slots could only stay low by reset
        issue_ready = 1'b1;
        imem_valid = 1'b0;
        imem_data = '0;
        seed = 65713;
        // unlisted words: addiu built from their own address
        for (int i = 0; i < IMG_WORDS; i++) begin
            img[i] = {6'h09, 5'(i >> 3), 5'(i), 16'(i * 4)};
        end
        // empty command slots read as end of list
        for (int i = CMD_BASE; i < IMG_SIZE; i++) begin
            img[i] = 32'hffff_ffff;
        end
        $readmemh("frontend_cases.txt", img);

        // reset, nothing may move
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_value(32'(imem_req), 0, "imem_req in reset");
            check_value(32'(master.valid), 0, "master.valid in reset");
            check_value(32'(slave.valid), 0, "slave.valid in reset");
        end

        cyc = '0;
        exp_pc = RESET_PC;
        exp_ds = 1'b0;
        exp_addr = {RESET_PC[31:3], 3'b000};
        avail = 0;
        since_flush = 0;
        cmd_idx = 0;
        quiet = 1'b1;
        first_upper = RESET_PC[2];
        stall_end = '0;
        req_q = 1'b0;
        live_q = 1'b0;
        addr_q = '0;

        while (!((img[CMD_BASE + 3 * cmd_idx] == 32'hffff_ffff)
                 && (since_flush >= RUN_AFTER_LAST))) begin
            if (cyc >= MAX_CYCLES) begin
                $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
                $display("Test failures found");
                $fatal(1, "timeout");
            end
            fifo_rst = 1'b0;
            // command due this cycle
            flush_now = 1'b0;
            if (img[CMD_BASE + 3 * cmd_idx] == cyc) begin
                if (img[CMD_BASE + 3 * cmd_idx + 1] == CMD_FLUSH) begin
                    flush_now = 1'b1;
                    flush_pc = img[CMD_BASE + 3 * cmd_idx + 2];
                end else begin
                    stall_end = cyc + img[CMD_BASE + 3 * cmd_idx + 2];
                end
                cmd_idx++;
            end
            flush = flush_now;
            // decode stalls about one cycle in four
            issue_ready = (cyc < stall_end) ? 1'b0 : (($random(seed) & 3) != 0);
            // memory answers last cycle's request, low word first
            imem_valid = req_q;
            imem_data = req_q ? {word_at(addr_q + 32'd4), word_at(addr_q)} : '0;
            #2;

            // fetch asks only with four free entries, never right after a restart
            exp_req = !quiet && (avail <= FIFO_DEPTH - 4);
            check_value(32'(imem_req), 32'(exp_req), "imem_req");
            if (exp_req) begin
                check_value(imem_addr, exp_addr, "imem_addr");
            end
            if (cyc + 32'd1 == stall_end) begin
                check_value(32'(imem_req), 0, "imem_req at end of long stall");
            end

            m_word = word_at(exp_pc);
            s_word = word_at(exp_pc + 32'd4);
            m_exp = issue_ready && (avail >= 1);
            s_exp = m_exp && (avail >= 2) && pair_ok(m_word, s_word);
            check_value(32'(master.valid), 32'(m_exp), "master.valid");
            check_value(32'(slave.valid), 32'(s_exp), "slave.valid");
            if (m_exp) begin
                check_value(master.pc, exp_pc, "master.pc");
                check_value(master.word, m_word, "master.word");
                check_value(32'(master.in_delay_slot), 32'(exp_ds), "master.in_delay_slot");
            end
            if (s_exp) begin
                check_value(slave.pc, exp_pc + 32'd4, "slave.pc");
                check_value(slave.word, s_word, "slave.word");
                check_value(32'(slave.in_delay_slot), 0, "slave.in_delay_slot");
            end

            // advance program order
            if (m_exp) begin
                exp_ds = branch_word(m_word) && !s_exp;
                exp_pc = exp_pc + (s_exp ? 32'd8 : 32'd4);
                avail = avail - (s_exp ? 2 : 1);
                since_flush = since_flush + (s_exp ? 2 : 1);
            end
            // response lands unless a flush drops it
            if (live_q && !flush_now) begin
                avail = avail + (first_upper ? 1 : 2);
                first_upper = 1'b0;
            end
            // next pair follows the last one, a flush restarts at its target
            if (flush_now) begin
                exp_addr = {flush_pc[31:3], 3'b000};
            end else if (exp_req) begin
                exp_addr = exp_addr + 32'd8;
            end
            quiet = flush_now;
            if (flush_now) begin
                exp_pc = flush_pc;
                exp_ds = 1'b0;
                avail = 0;
                first_upper = flush_pc[2];
                since_flush = 0;
            end
            req_q = imem_req;
            live_q = imem_req && !flush_now;
            addr_q = imem_addr;
            cyc = cyc + 32'd1;
            @(negedge clk);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

// File: frontend_cases.txt
// program image: one 32-bit hex word each, word address = pc / 4
// commands from word 100: cycle, kind (1 flush, 2 stall), target pc or stall length
@000
20080001 21090002 01095020 00000000 // addi, hazard on rs, add, nop
11090003 214a0001 016c6820 01ae7020 // beq with its delay slot
03e00008 00000000 15cdfff0 01cf8020 // jr, nop, bne, delay slot
3c110010 02318820 10000004 10000002 // lui, hazard, two branches in a row
8e120004 ae120008 02539820 0274a022 // lw at 0x40, sw hazard on rt
0295a825 00000000 3c160001 02d6b020
03e00008 26f70001 12f8fffe 02f8c82a
0339d020 00000000 00000000 14000001
214a0001 11090003 11090003 01cf8020
@100
00000050 00000002 00000028 // cycle 80, stall decode for 40 cycles
000000a0 00000001 00000040 // cycle 160, flush to aligned 0x40
00000104 00000001 00000014 // cycle 260, flush to upper word 0x14
0000017c 00000001 00000008 // cycle 380, flush to aligned 0x08
ffffffff

// File: build.f
inst_pkg.sv
fetch_unit.sv
inst_fifo.sv
issue_unit.sv
frontend_top.sv
tb_frontend.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the front end with its testbench and run it under Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_frontend -f build.f \
    -o tb_frontend_sim > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/tb_frontend_sim > sim.log 2>&1
cat sim.log

grep -q "Test failures found" sim.log && { echo "simulation failed"; exit 1; }
grep -q "All tests passed!" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
